// File: common/processorPkg.sv
// Shared widths, opcode and ALU enums, forwarding selects and instruction field helpers.
`default_nettype none

package processorPkg;

    typedef logic [31:0] dataWord;
    typedef logic [4:0]  regAddr;
    typedef logic [15:0] instrAddr;
    typedef logic [31:0] instrWord;

    typedef enum logic [5:0] {
        opRType = 6'h00,
        opJ     = 6'h02,
        opBeq   = 6'h04,
        opBne   = 6'h05,
        opAddi  = 6'h08,
        opLw    = 6'h23,
        opSw    = 6'h2b
    } opcodeT;

    // Each ALU operation carries the funct code of its R-type instruction.
    typedef enum logic [5:0] {
        aluSll = 6'h00,
        aluAdd = 6'h20,
        aluSub = 6'h22,
        aluAnd = 6'h24,
        aluOr  = 6'h25,
        aluXor = 6'h26,
        aluSlt = 6'h2a
    } aluFuncT;

    typedef enum logic [1:0] {
        fwdRegister,
        fwdMemory,
        fwdWriteback
    } forwardSelT;

    function automatic opcodeT getOpcode(instrWord instr);
        return opcodeT'(instr[31:26]);
    endfunction

    function automatic regAddr getRs(instrWord instr);
        return instr[25:21];
    endfunction

    function automatic regAddr getRt(instrWord instr);
        return instr[20:16];
    endfunction

    function automatic regAddr getRd(instrWord instr);
        return instr[15:11];
    endfunction

    function automatic logic [4:0] getShamt(instrWord instr);
        return instr[10:6];
    endfunction

    function automatic logic [5:0] getFunct(instrWord instr);
        return instr[5:0];
    endfunction

    function automatic dataWord getImmediate(instrWord instr);
        return {{16{instr[15]}}, instr[15:0]};
    endfunction

endpackage

`default_nettype wire

// File: common/stageIf.sv
// Decode-to-execute register bundle with its decoder and executor modports.
`default_nettype none

interface stageIf import processorPkg::*; ();

    logic       regWrite;
    logic       memRead;
    logic       memWrite;
    logic       memToReg;
    aluFuncT    aluFunc;
    logic       useImm;
    logic       branchEq;
    logic       branchNe;
    logic       jump;
    dataWord    immediate;
    logic [4:0] shamt;
    dataWord    rsData;
    dataWord    rtData;
    regAddr     rsAddr;
    regAddr     rtAddr;
    regAddr     destAddr;
    instrAddr   pc;

    modport decoder (
        output regWrite, memRead, memWrite, memToReg, aluFunc, useImm, branchEq, branchNe,
               jump, immediate, shamt, rsData, rtData, rsAddr, rtAddr, destAddr, pc
    );

    modport executor (
        input regWrite, memRead, memWrite, memToReg, aluFunc, useImm, branchEq, branchNe,
              jump, immediate, shamt, rsData, rtData, rsAddr, rtAddr, destAddr, pc
    );

endinterface

`default_nettype wire

// File: hdl/fetchStage.sv
// Program counter with redirect and stall, and the fetch-to-decode register.
`default_nettype none

module fetchStage import processorPkg::*; #(
    parameter instrAddr ResetAddress = 16'h0000
) (
    input  logic     Clock,
    input  logic     nReset,
    input  logic     nStall,
    input  logic     branchTaken,
    input  instrAddr branchTarget,
    input  instrWord InstrMem,
    output instrAddr InstrAddr,
    output instrWord instruction,
    output instrAddr pc,
    output logic     valid
);

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            InstrAddr <= ResetAddress;
            valid     <= 1'b0;
        end else if (branchTaken) begin
            InstrAddr <= branchTarget;
            valid     <= 1'b0;              // The word fetched behind the branch is dropped.
        end else if (nStall) begin
            InstrAddr <= InstrAddr + 16'd4;
            valid     <= 1'b1;
        end
    end

    always_ff @(posedge Clock) begin
        if (nStall && !branchTaken) begin
            instruction <= InstrMem;
            pc          <= InstrAddr;
        end
    end

endmodule

`default_nettype wire

// File: hdl/decodeStage.sv
// Instruction decoder, register file with debug read port, and the decode-to-execute register.
`default_nettype none

module decodeStage import processorPkg::*; (
    input  logic     Clock,
    input  logic     nReset,
    input  logic     nStall,
    input  logic     flush,
    input  instrWord instruction,
    input  instrAddr pc,
    input  logic     valid,
    input  logic     wbWrite,
    input  regAddr   wbAddr,
    input  dataWord  wbData,
    input  regAddr   RegAddr,
    output dataWord  RegData,
    stageIf.decoder  toExecute
);

    dataWord registers [32];
    regAddr  rsAddr;
    regAddr  rtAddr;
    regAddr  destAddr;
    dataWord rsData;
    dataWord rtData;
    aluFuncT aluFunc;
    logic    regWrite;
    logic    memRead;
    logic    memWrite;
    logic    memToReg;
    logic    useImm;
    logic    branchEq;
    logic    branchNe;
    logic    jump;
    logic    issue;

    assign rsAddr = getRs(instruction);
    assign rtAddr = getRt(instruction);
    assign issue  = valid && nStall && !flush;  // Otherwise a bubble goes to execute.

    always_comb begin
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        memToReg = 1'b0;
        useImm   = 1'b1;
        branchEq = 1'b0;
        branchNe = 1'b0;
        jump     = 1'b0;
        aluFunc  = aluAdd;
        destAddr = rtAddr;
        case (getOpcode(instruction))
            opRType: begin
                useImm   = 1'b0;
                destAddr = getRd(instruction);
                aluFunc  = aluFuncT'(getFunct(instruction));
                regWrite = aluFunc inside {aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSll};
            end
            opAddi: regWrite = 1'b1;
            opLw: begin
                regWrite = 1'b1;
                memRead  = 1'b1;
                memToReg = 1'b1;
            end
            opSw:  memWrite = 1'b1;
            opBeq: branchEq = 1'b1;
            opBne: branchNe = 1'b1;
            opJ:   jump = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (wbWrite && wbAddr != '0) begin
            registers[wbAddr] <= wbData;
        end
    end

    // Write-through, so a value written this cycle is already visible.
    assign rsData = (rsAddr == '0) ? '0 :
                    (wbWrite && wbAddr == rsAddr) ? wbData : registers[rsAddr];
    assign rtData = (rtAddr == '0) ? '0 :
                    (wbWrite && wbAddr == rtAddr) ? wbData : registers[rtAddr];
    assign RegData = (RegAddr == '0) ? '0 : registers[RegAddr];

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            toExecute.regWrite <= 1'b0;
            toExecute.memRead  <= 1'b0;
            toExecute.memWrite <= 1'b0;
            toExecute.memToReg <= 1'b0;
            toExecute.branchEq <= 1'b0;
            toExecute.branchNe <= 1'b0;
            toExecute.jump     <= 1'b0;
        end else begin
            toExecute.regWrite <= issue && regWrite;
            toExecute.memRead  <= issue && memRead;
            toExecute.memWrite <= issue && memWrite;
            toExecute.memToReg <= issue && memToReg;
            toExecute.branchEq <= issue && branchEq;
            toExecute.branchNe <= issue && branchNe;
            toExecute.jump     <= issue && jump;
        end
    end

    always_ff @(posedge Clock) begin
        toExecute.aluFunc   <= aluFunc;
        toExecute.useImm    <= useImm;
        toExecute.immediate <= getImmediate(instruction);
        toExecute.shamt     <= getShamt(instruction);
        toExecute.rsData    <= rsData;
        toExecute.rtData    <= rtData;
        toExecute.rsAddr    <= rsAddr;
        toExecute.rtAddr    <= rtAddr;
        toExecute.destAddr  <= destAddr;
        toExecute.pc        <= pc;
    end

endmodule

`default_nettype wire

// File: hdl/executeStage.sv
// Operand forwarding muxes, ALU, branch decision and target, and the execute-to-memory register.
`default_nettype none

module executeStage import processorPkg::*; (
    input  logic       Clock,
    input  logic       nReset,
    stageIf.executor   fromDecode,
    input  forwardSelT selA,
    input  forwardSelT selB,
    input  dataWord    memResult,
    input  dataWord    wbData,
    output logic       branchTaken,
    output instrAddr   branchTarget,
    output dataWord    result,
    output dataWord    storeData,
    output regAddr     destAddr,
    output logic       regWrite,
    output logic       memRead,
    output logic       memWrite,
    output logic       memToReg
);

    dataWord  opA;
    dataWord  opB;
    dataWord  aluB;
    dataWord  aluOut;
    instrAddr offset;

    function automatic dataWord pickOperand(forwardSelT sel, dataWord fromReg,
                                            dataWord fromMem, dataWord fromWb);
        case (sel)
            fwdMemory:    return fromMem;
            fwdWriteback: return fromWb;
            default:      return fromReg;
        endcase
    endfunction

    assign opA  = pickOperand(selA, fromDecode.rsData, memResult, wbData);
    assign opB  = pickOperand(selB, fromDecode.rtData, memResult, wbData);
    assign aluB = fromDecode.useImm ? fromDecode.immediate : opB;

    always_comb begin
        case (fromDecode.aluFunc)
            aluSub:  aluOut = opA - aluB;
            aluAnd:  aluOut = opA & aluB;
            aluOr:   aluOut = opA | aluB;
            aluXor:  aluOut = opA ^ aluB;
            aluSlt:  aluOut = {31'b0, $signed(opA) < $signed(aluB)};
            aluSll:  aluOut = opB << fromDecode.shamt;
            default: aluOut = opA + aluB;
        endcase
    end

    // Word offset for branches and the word address for jumps share the low field bits.
    assign offset       = {fromDecode.immediate[13:0], 2'b00};
    assign branchTaken  = fromDecode.jump
                          || (fromDecode.branchEq && opA == opB)
                          || (fromDecode.branchNe && opA != opB);
    assign branchTarget = fromDecode.jump ? offset : fromDecode.pc + 16'd4 + offset;

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            regWrite <= 1'b0;
            memRead  <= 1'b0;
            memWrite <= 1'b0;
            memToReg <= 1'b0;
        end else begin
            regWrite <= fromDecode.regWrite;
            memRead  <= fromDecode.memRead;
            memWrite <= fromDecode.memWrite;
            memToReg <= fromDecode.memToReg;
        end
    end

    always_ff @(posedge Clock) begin
        result    <= aluOut;
        storeData <= opB;                   // Forwarded value, so a store sees fresh data.
        destAddr  <= fromDecode.destAddr;
    end

endmodule

`default_nettype wire

// File: hdl/memoryStage.sv
// Data memory port drive, memory-to-writeback register and writeback data select.
`default_nettype none

module memoryStage import processorPkg::*; (
    input  logic     Clock,
    input  logic     nReset,
    input  dataWord  result,
    input  dataWord  storeData,
    input  regAddr   destAddr,
    input  logic     regWrite,
    input  logic     memRead,
    input  logic     memWrite,
    input  logic     memToReg,
    input  dataWord  MemData,
    output instrAddr MemAddr,
    output dataWord  WriteData,
    output logic     MemWrite,
    output logic     MemRead,
    output dataWord  memResult,
    output logic     wbWrite,
    output regAddr   wbAddr,
    output dataWord  wbData
);

    logic    wbMemToReg;
    dataWord wbResult;

    assign MemAddr   = result[15:0];
    assign WriteData = storeData;
    assign MemWrite  = memWrite;
    assign MemRead   = memRead;
    assign memResult = result;

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            wbWrite    <= 1'b0;
            wbMemToReg <= 1'b0;
        end else begin
            wbWrite    <= regWrite;
            wbMemToReg <= memToReg;
        end
    end

    always_ff @(posedge Clock) begin
        wbAddr   <= destAddr;
        wbResult <= result;
    end

    // Load data arrives from the synchronous memory during writeback.
    assign wbData = wbMemToReg ? MemData : wbResult;

endmodule

`default_nettype wire

// File: hdl/forwardingUnit.sv
// Execute operand forwarding selects and the load-use stall decision.
`default_nettype none

module forwardingUnit import processorPkg::*; (
    input  regAddr     exRsAddr,
    input  regAddr     exRtAddr,
    input  regAddr     decRsAddr,
    input  regAddr     decRtAddr,
    input  regAddr     memDestAddr,
    input  regAddr     wbAddr,
    input  logic       memRegWrite,
    input  logic       wbWrite,
    input  logic       exMemRead,
    input  regAddr     exDestAddr,
    output forwardSelT selA,
    output forwardSelT selB,
    output logic       nStall
);

    // The memory stage holds the younger result, so it wins over writeback.
    function automatic forwardSelT sourceFor(regAddr src, logic memWe, regAddr memDest,
                                             logic wbWe, regAddr wbDest);
        return (src == '0)               ? fwdRegister  :
               (memWe && memDest == src) ? fwdMemory    :
               (wbWe && wbDest == src)   ? fwdWriteback : fwdRegister;
    endfunction

    assign selA = sourceFor(exRsAddr, memRegWrite, memDestAddr, wbWrite, wbAddr);
    assign selB = sourceFor(exRtAddr, memRegWrite, memDestAddr, wbWrite, wbAddr);

    // A load in execute has no data yet for the instruction in decode.
    assign nStall = !(exMemRead && exDestAddr != '0
                      && (exDestAddr == decRsAddr || exDestAddr == decRtAddr));

endmodule

`default_nettype wire

// File: hdl/processor.sv
// Five-stage pipelined core top level with memory and debug ports.
`default_nettype none

module processor import processorPkg::*; #(
    parameter instrAddr ResetAddress = 16'h0000
) (
    input  logic     Clock,
    input  logic     nReset,
    input  instrWord InstrMem,
    output instrAddr InstrAddr,
    input  dataWord  MemData,
    output instrAddr MemAddr,
    output dataWord  WriteData,
    output logic     MemWrite,
    output logic     MemRead,
    input  regAddr   RegAddr,
    output dataWord  RegData,
    output logic     nStall
);

    instrWord   decInstruction;
    instrAddr   decPc;
    logic       decValid;
    logic       branchTaken;
    instrAddr   branchTarget;
    dataWord    aluResult;
    dataWord    storeWord;
    regAddr     memDestAddr;
    logic       memRegWrite;
    logic       memLoad;
    logic       memStore;
    logic       memToReg;
    dataWord    memResult;
    logic       wbWrite;
    regAddr     wbAddr;
    dataWord    wbData;
    forwardSelT selA;
    forwardSelT selB;

    stageIf stageBus ();

    fetchStage #(.ResetAddress(ResetAddress)) fetch (
        .Clock        (Clock),
        .nReset       (nReset),
        .nStall       (nStall),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .InstrMem     (InstrMem),
        .InstrAddr    (InstrAddr),
        .instruction  (decInstruction),
        .pc           (decPc),
        .valid        (decValid)
    );

    decodeStage decode (
        .Clock       (Clock),
        .nReset      (nReset),
        .nStall      (nStall),
        .flush       (branchTaken),         // Squashes the instruction behind a taken branch.
        .instruction (decInstruction),
        .pc          (decPc),
        .valid       (decValid),
        .wbWrite     (wbWrite),
        .wbAddr      (wbAddr),
        .wbData      (wbData),
        .RegAddr     (RegAddr),
        .RegData     (RegData),
        .toExecute   (stageBus.decoder)
    );

    executeStage execute (
        .Clock        (Clock),
        .nReset       (nReset),
        .fromDecode   (stageBus.executor),
        .selA         (selA),
        .selB         (selB),
        .memResult    (memResult),
        .wbData       (wbData),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .result       (aluResult),
        .storeData    (storeWord),
        .destAddr     (memDestAddr),
        .regWrite     (memRegWrite),
        .memRead      (memLoad),
        .memWrite     (memStore),
        .memToReg     (memToReg)
    );

    memoryStage memory (
        .Clock     (Clock),
        .nReset    (nReset),
        .result    (aluResult),
        .storeData (storeWord),
        .destAddr  (memDestAddr),
        .regWrite  (memRegWrite),
        .memRead   (memLoad),
        .memWrite  (memStore),
        .memToReg  (memToReg),
        .MemData   (MemData),
        .MemAddr   (MemAddr),
        .WriteData (WriteData),
        .MemWrite  (MemWrite),
        .MemRead   (MemRead),
        .memResult (memResult),
        .wbWrite   (wbWrite),
        .wbAddr    (wbAddr),
        .wbData    (wbData)
    );

    forwardingUnit forwarding (
        .exRsAddr    (stageBus.rsAddr),
        .exRtAddr    (stageBus.rtAddr),
        .decRsAddr   (getRs(decInstruction)),
        .decRtAddr   (getRt(decInstruction)),
        .memDestAddr (memDestAddr),
        .wbAddr      (wbAddr),
        .memRegWrite (memRegWrite),
        .wbWrite     (wbWrite),
        .exMemRead   (stageBus.memRead),
        .exDestAddr  (stageBus.destAddr),
        .selA        (selA),
        .selB        (selB),
        .nStall      (nStall)
    );

endmodule

`default_nettype wire

// File: dv/processorModel.svh
// Instruction encoders, random program generator and instruction-level reference model.
`ifndef PROCESSOR_MODEL_SVH
`define PROCESSOR_MODEL_SVH

localparam int       ProgramLength = 40;
localparam int       HaltIndex     = ProgramLength - 1;
localparam instrAddr HaltAddress   = StartAddress + instrAddr'(4 * HaltIndex);
localparam instrAddr DataBase      = 16'h0100;

integer   seed = 32'hf17c23f5;
instrWord progMem [16384];
dataWord  modelMem [16384];
dataWord  modelRegs [32];
logic     modelKnown [32];                  // Registers that hold a defined value.
instrAddr expAddr [$];
dataWord  expData [$];

function automatic dataWord fillWord(instrAddr addr);
    return {~addr, addr} ^ 32'h3c5a96e1;
endfunction

function automatic int slot(int index);
    return int'(StartAddress[15:2]) + index;
endfunction

function automatic instrWord encodeR(aluFuncT funct, regAddr rd, regAddr rs, regAddr rt,
                                     logic [4:0] shamt);
    return {opRType, rs, rt, rd, shamt, funct};
endfunction

function automatic instrWord encodeI(opcodeT op, regAddr rs, regAddr rt, logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic instrWord encodeJ(int index);
    instrAddr target;
    target = StartAddress + instrAddr'(4 * index);
    return {opJ, 12'b0, target[15:2]};
endfunction

task automatic resetModel();
    int i;
    for (i = 0; i < 16384; i++) begin
        modelMem[i] = fillWord(instrAddr'(i * 4));
        progMem[i]  = '0;
    end
    for (i = 0; i < 32; i++) begin
        modelRegs[i]  = '0;
        modelKnown[i] = (i == 0);
    end
endtask

// Registers r1 to r7 are set first, then a load feeds the next instruction.
task automatic makeProgram();
    int          i;
    int          hop;
    logic [31:0] rnd;
    regAddr      rd;
    regAddr      rs;
    regAddr      rt;
    logic [15:0] dataOffset;
    logic [15:0] hopImm;
    for (i = 0; i < 7; i++) begin
        rnd = $random(seed);
        progMem[slot(i)] = encodeI(opAddi, 5'd0, regAddr'(i + 1), rnd[15:0]);
    end
    rnd = $random(seed);
    progMem[slot(7)] = encodeI(opLw, 5'd0, 5'd1, DataBase + {11'b0, rnd[2:0], 2'b00});
    progMem[slot(8)] = encodeR(aluAdd, 5'd2, 5'd1, 5'd1, 5'd0);
    for (i = 9; i < HaltIndex; i++) begin
        rnd        = $random(seed);
        rd         = {2'b00, rnd[10:8]};
        rs         = {2'b00, rnd[13:11]};
        rt         = {2'b00, rnd[16:14]};
        dataOffset = DataBase + {11'b0, rnd[19:17], 2'b00};
        hop        = int'(rnd[21:20]);
        if (i + 1 + hop > HaltIndex) begin
            hop = HaltIndex - i - 1;        // Never branch past the halt instruction.
        end
        hopImm = 16'(hop);
        case (rnd[3:0])
            4'd0:         progMem[slot(i)] = encodeR(aluAdd, rd, rs, rt, 5'd0);
            4'd1:         progMem[slot(i)] = encodeR(aluSub, rd, rs, rt, 5'd0);
            4'd2:         progMem[slot(i)] = encodeR(aluAnd, rd, rs, rt, 5'd0);
            4'd3:         progMem[slot(i)] = encodeR(aluOr, rd, rs, rt, 5'd0);
            4'd4:         progMem[slot(i)] = encodeR(aluXor, rd, rs, rt, 5'd0);
            4'd5:         progMem[slot(i)] = encodeR(aluSlt, rd, rs, rt, 5'd0);
            4'd6:         progMem[slot(i)] = encodeR(aluSll, rd, 5'd0, rt, rnd[26:22]);
            4'd7, 4'd8:   progMem[slot(i)] = encodeI(opAddi, rs, rd, rnd[31:16]);
            4'd9, 4'd10:  progMem[slot(i)] = encodeI(opLw, 5'd0, rd, dataOffset);
            4'd11, 4'd12: progMem[slot(i)] = encodeI(opSw, 5'd0, rt, dataOffset);
            4'd13:        progMem[slot(i)] = encodeI(opBeq, rs, rt, hopImm);
            4'd14:        progMem[slot(i)] = encodeI(opBne, rs, rt, hopImm);
            default:      progMem[slot(i)] = encodeJ(i + 1 + hop);
        endcase
    end
    progMem[slot(HaltIndex)] = encodeJ(HaltIndex);
endtask

function automatic dataWord modelAlu(logic [5:0] funct, dataWord a, dataWord b,
                                     logic [4:0] shamt);
    case (funct)
        aluAdd:  return a + b;
        aluSub:  return a - b;
        aluAnd:  return a & b;
        aluOr:   return a | b;
        aluXor:  return a ^ b;
        aluSlt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        aluSll:  return b << shamt;
        default: return '0;
    endcase
endfunction

task automatic writeReg(regAddr r, dataWord value);
    if (r != 5'd0) begin
        modelRegs[r]  = value;
        modelKnown[r] = 1'b1;
    end
endtask

task automatic runModel();
    int       steps;
    instrAddr pc;
    instrWord instr;
    dataWord  a;
    dataWord  b;
    dataWord  imm;
    instrAddr addr;
    expAddr.delete();
    expData.delete();
    pc = StartAddress;
    for (steps = 0; steps < ProgramLength && pc != HaltAddress; steps++) begin
        instr = progMem[pc[15:2]];
        a     = modelRegs[instr[25:21]];
        b     = modelRegs[instr[20:16]];
        imm   = {{16{instr[15]}}, instr[15:0]};
        addr  = a[15:0] + imm[15:0];
        pc    = pc + 16'd4;
        case (instr[31:26])
            opRType: writeReg(instr[15:11], modelAlu(instr[5:0], a, b, instr[10:6]));
            opAddi:  writeReg(instr[20:16], a + imm);
            opLw:    writeReg(instr[20:16], modelMem[addr[15:2]]);
            opSw: begin
                modelMem[addr[15:2]] = b;
                expAddr.push_back(addr);
                expData.push_back(b);
            end
            opBeq:   pc = (a == b) ? pc + (imm[15:0] << 2) : pc;
            opBne:   pc = (a != b) ? pc + (imm[15:0] << 2) : pc;
            opJ:     pc = instr[15:0] << 2;
            default: ;
        endcase
    end
endtask

`endif

// File: dv/processorTb.sv
// Testbench for the pipelined core with memory models, reference checks and a watchdog.
`default_nettype none

module processorTb import processorPkg::*; ();

    localparam instrAddr StartAddress   = 16'h0040;
    localparam int       ProgramCount   = 5;
    localparam int       WatchdogCycles = ProgramCount * 40 * 6 + 100;
    localparam int       HaltWaitCycles = 8;

    logic     Clock;
    logic     nReset;
    instrWord InstrMem;
    instrAddr InstrAddr;
    dataWord  MemData;
    instrAddr MemAddr;
    dataWord  WriteData;
    logic     MemWrite;
    logic     MemRead;
    regAddr   RegAddr;
    dataWord  RegData;
    logic     nStall;

    dataWord  dataMem [16384];
    logic     readPending;
    instrAddr readAddr;
    logic     lastStalled;
    int       storeIndex;
    int       storeErrors;
    int       stallCount;
    int       stallErrors;
    int       mainErrors;

    `include "processorModel.svh"

    localparam int HaltLimit = ProgramLength * 4;

    processor #(.ResetAddress(StartAddress)) dut_i (.*);

    initial begin
        Clock = 1'b0;
        forever #20 Clock = ~Clock;
    end

    always_comb InstrMem = progMem[InstrAddr[15:2]];   // Asynchronous instruction read.

    task automatic checkStore(instrAddr addr, dataWord data);
        if (storeIndex < expAddr.size()) begin
            assert (addr == expAddr[storeIndex]) else begin
                storeErrors++;
                $display("Error: MemAddr is %h, expected %h", addr, expAddr[storeIndex]);
            end
            assert (data == expData[storeIndex]) else begin
                storeErrors++;
                $display("Error: WriteData is %h, expected %h", data, expData[storeIndex]);
            end
        end else begin
            storeErrors++;
            $display("Unexpected store to address %h after the last expected store", addr);
        end
        storeIndex++;
    endtask

    // Data memory writes at the edge and returns read data half a cycle later.
    initial begin
        int i;
        for (i = 0; i < 16384; i++) begin
            dataMem[i] = fillWord(instrAddr'(i * 4));
        end
        storeIndex  = 0;
        storeErrors = 0;
        readPending = 1'b0;
        readAddr    = '0;
        forever begin
            @(posedge Clock);
            if (!nReset) begin
                storeIndex = 0;
            end
            if (MemWrite) begin
                checkStore(MemAddr, WriteData);
                dataMem[MemAddr[15:2]] = WriteData;
            end
            readPending = MemRead;
            readAddr    = MemAddr;
        end
    end

    initial begin
        MemData = '0;
        forever begin
            @(negedge Clock);
            if (readPending) begin
                MemData = dataMem[readAddr[15:2]];
            end
        end
    end

    initial begin
        stallCount  = 0;
        stallErrors = 0;
        lastStalled = 1'b0;
        forever begin
            @(negedge Clock);
            if (!nStall) begin
                stallCount++;
                assert (!lastStalled) else begin
                    stallErrors++;
                    $display("nStall stayed low for more than one cycle at time %0t", $time);
                end
            end
            lastStalled = !nStall;
        end
    end

    task automatic applyReset();
        @(negedge Clock);
        nReset = 1'b0;
        repeat (3) @(negedge Clock);
        assert (InstrAddr == StartAddress) else begin
            mainErrors++;
            $display("Error: InstrAddr is %h, expected %h", InstrAddr, StartAddress);
        end
        assert (!MemWrite) else begin
            mainErrors++;
            $display("Error: MemWrite is %h, expected 0", MemWrite);
        end
        assert (!MemRead) else begin
            mainErrors++;
            $display("Error: MemRead is %h, expected 0", MemRead);
        end
        assert (nStall) else begin
            mainErrors++;
            $display("Error: nStall is %h, expected 1", nStall);
        end
        nReset = 1'b1;
    endtask

    task automatic waitForHalt(int prog);
        int cycles;
        cycles = 0;
        while (InstrAddr != HaltAddress && cycles < HaltLimit) begin
            @(negedge Clock);
            cycles++;
        end
        assert (InstrAddr == HaltAddress) else begin
            mainErrors++;
            $display("Program %0d did not reach the halt address in time", prog);
        end
        repeat (HaltWaitCycles) @(negedge Clock);
    endtask

    task automatic checkRegisters(int prog);
        int r;
        for (r = 0; r < 32; r++) begin
            RegAddr = regAddr'(r);
            @(negedge Clock);
            if (modelKnown[r]) begin
                assert (RegData == modelRegs[r]) else begin
                    mainErrors++;
                    $display("Error: RegData of register %0d in program %0d is %h, expected %h",
                             r, prog, RegData, modelRegs[r]);
                end
            end
        end
    endtask

    initial begin
        int prog;
        nReset     = 1'b0;
        RegAddr    = '0;
        mainErrors = 0;
        resetModel();
        for (prog = 0; prog < ProgramCount; prog++) begin
            makeProgram();
            runModel();
            applyReset();
            waitForHalt(prog);
            checkRegisters(prog);
            assert (storeIndex == expAddr.size()) else begin
                mainErrors++;
                $display("Program %0d made %0d stores where the model made %0d",
                         prog, storeIndex, expAddr.size());
            end
        end
        assert (stallCount > 0) else begin
            mainErrors++;
            $display("No load-use stall was seen during the run");
        end
        $display("Checks done: %0d main, %0d store and %0d stall errors, %0d stall cycles",
                 mainErrors, storeErrors, stallErrors, stallCount);
        if (mainErrors + storeErrors + stallErrors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        repeat (WatchdogCycles) @(posedge Clock);
        $display("Timeout: the run did not finish within %0d cycles", WatchdogCycles);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+dv
common/processorPkg.sv
common/stageIf.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/forwardingUnit.sv
hdl/processor.sv
dv/processorTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       ?= processorTb
FILELIST  ?= project.f
BUILD     ?= obj_dir
PASS      := all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD) -o $(TOP)
	@output="$$(./$(BUILD)/$(TOP))"; \
	echo "$$output"; \
	echo "$$output" | grep -qx "$(PASS)"

clean:
	rm -rf $(BUILD)
